// ==== common/can_rx_pkg.sv ====
package can_rx_pkg;

    // Message fields
    typedef logic [28:0] can_id_t;   // Base ID in 28..18, extension in 17..0
    typedef logic [63:0] can_data_t; // First bit on the line lands in bit 63
    typedef logic [3:0]  can_dlc_t;
    typedef logic [14:0] can_crc_t;

    // Bit timing
    typedef logic [8:0] quantum_t;
    typedef logic [6:0] seg_len_t;

    localparam seg_len_t PROP_SEG   = 7'd3;
    localparam seg_len_t PHASE_SEG1 = 7'd6;
    localparam seg_len_t PHASE_SEG2 = 7'd6;
    localparam seg_len_t SJW        = 7'd2;

    localparam quantum_t BIT_QUANTA   = quantum_t'(1 + PROP_SEG + PHASE_SEG1 + PHASE_SEG2);
    localparam quantum_t SAMPLE_POINT = quantum_t'(1 + PROP_SEG + PHASE_SEG1);

    localparam can_crc_t CRC15_POLY = 15'h4599;

    // Frame sizes
    localparam int MAX_DATA_BYTES    = 8;
    localparam int STUFF_RUN         = 5;
    localparam int EOF_BITS          = 7;
    localparam int ERR_DELIM_BITS    = 8;
    localparam int INTERMISSION_BITS = 3;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_ID,
        ST_RTR_SRR,
        ST_IDE,
        ST_R1,
        ST_R0,
        ST_DLC,
        ST_DATA,
        ST_CRC,
        ST_CRC_DELIM,
        ST_ACK_SLOT,
        ST_ACK_DELIM,
        ST_EOF,
        ST_INTERMISSION,
        ST_ERROR_FLAG,
        ST_ERROR_DELIM
    } rx_state_e;

endpackage

// ==== bit_timing/can_bit_sampler.sv ====
`timescale 1ns/1ns

module can_bit_sampler
    import can_rx_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic rx_raw,
    input  logic bus_idle,
    output logic rx_bit,
    output logic sample_strobe,
    output logic sync_tick
);

    quantum_t quantum;
    quantum_t sample_pt;
    quantum_t bit_end;
    seg_len_t seg1_ext;   // Phase segment 1 lengthening for this bit
    seg_len_t seg2_cut;   // Phase segment 2 shortening for this bit
    logic     rx_meta;
    logic     rx_sync;
    logic     rx_last;
    logic     edge_seen;
    logic     near_start;
    logic     near_end;

    assign sample_pt  = SAMPLE_POINT + quantum_t'(seg1_ext);
    assign bit_end    = BIT_QUANTA - 9'd1 + quantum_t'(seg1_ext) - quantum_t'(seg2_cut);
    assign edge_seen  = rx_sync ^ rx_last;
    assign near_start = quantum < quantum_t'(SJW);
    assign near_end   = (bit_end - quantum) < quantum_t'(SJW);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_meta       <= 1'b0;
            rx_sync       <= 1'b0;
            rx_last       <= 1'b0;
            quantum       <= '0;
            seg1_ext      <= '0;
            seg2_cut      <= '0;
            rx_bit        <= 1'b0;
            sample_strobe <= 1'b0;
            sync_tick     <= 1'b0;
        end else begin
            rx_meta <= rx_raw;    // Two-stage synchronizer
            rx_sync <= rx_meta;
            rx_last <= rx_sync;

            sample_strobe <= (quantum == sample_pt);
            if (quantum == sample_pt)
                rx_bit <= rx_sync;

            if (edge_seen && (bus_idle || near_start || near_end)) begin
                // Hard sync, or an edge close enough to the boundary to restart
                quantum   <= '0;
                seg1_ext  <= '0;
                seg2_cut  <= '0;
                sync_tick <= !near_start; // Boundary already ticked just before
            end else if (quantum >= bit_end) begin
                quantum   <= '0;
                seg1_ext  <= '0;  // Back to nominal segments for the next bit
                seg2_cut  <= '0;
                sync_tick <= 1'b1;
            end else begin
                quantum   <= quantum + 9'd1;
                sync_tick <= 1'b0;
                if (edge_seen) begin
                    if (quantum <= sample_pt)
                        seg1_ext <= SJW;  // Late edge, push the sample point out
                    else
                        seg2_cut <= SJW;  // Early edge of the next bit
                end
            end
        end
    end

endmodule

// ==== src/can_destuffer.sv ====
`timescale 1ns/1ns

module can_destuffer
    import can_rx_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic sample_strobe,
    input  logic rx_bit,
    input  logic stuff_bypass,
    output logic bit_strobe,
    output logic bit_val,
    output logic stuff_error
);

    // Newest bit sits at the top, oldest at bit 0
    logic [STUFF_RUN-1:0] hist;
    logic [STUFF_RUN-1:0] hist_valid;
    logic [STUFF_RUN:0]   hist_next;
    logic [STUFF_RUN:0]   valid_next;
    logic                 run_full;
    logic                 run_same;
    logic                 all_same;

    assign hist_next  = {rx_bit, hist};
    assign valid_next = {1'b1, hist_valid};

    // The STUFF_RUN bits before the new one
    assign run_full = &valid_next[STUFF_RUN-1:0];
    assign run_same = (&hist_next[STUFF_RUN-1:0]) || !(|hist_next[STUFF_RUN-1:0]);
    assign all_same = (&hist_next) || !(|hist_next);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hist        <= '0;
            hist_valid  <= '0;
            bit_strobe  <= 1'b0;
            bit_val     <= 1'b0;
            stuff_error <= 1'b0;
        end else begin
            bit_strobe <= 1'b0;
            if (sample_strobe) begin
                if (stuff_bypass) begin
                    // Only the last bypassed bit is kept so SOF opens the run
                    hist        <= {rx_bit, {(STUFF_RUN-1){1'b0}}};
                    hist_valid  <= {1'b1, {(STUFF_RUN-1){1'b0}}};
                    stuff_error <= 1'b0;
                    bit_strobe  <= 1'b1;
                    bit_val     <= rx_bit;
                end else begin
                    hist       <= hist_next[STUFF_RUN:1];
                    hist_valid <= valid_next[STUFF_RUN:1];
                    if (run_full && all_same) begin
                        stuff_error <= 1'b1;      // Six equal bits
                    end else if (!(run_full && run_same)) begin
                        bit_strobe <= 1'b1;       // Stuff bits are dropped silently
                        bit_val    <= rx_bit;
                    end
                end
            end
        end
    end

endmodule

// ==== src/can_crc15.sv ====
`timescale 1ns/1ns

module can_crc15
    import can_rx_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     bit_val,
    input  logic     crc_update,
    input  logic     crc_clear,
    output can_crc_t crc_value
);

    logic feedback;

    assign feedback = bit_val ^ crc_value[14];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            crc_value <= '0;
        end else if (crc_clear) begin
            crc_value <= '0;
        end else if (crc_update) begin
            // Shift left, fold in the polynomial when the outgoing bit disagrees
            crc_value <= {crc_value[13:0], 1'b0} ^ (feedback ? CRC15_POLY : '0);
        end
    end

endmodule

// ==== frame_rx/can_frame_decoder.sv ====
`timescale 1ns/1ns

module can_frame_decoder
    import can_rx_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      bit_strobe,
    input  logic      bit_val,
    input  logic      stuff_error,
    input  logic      sync_tick,
    output logic      bus_idle,
    output logic      stuff_bypass,
    output logic      tx_raw,
    output can_id_t   msg_id,
    output logic      rtr,
    output logic      extended,
    output can_data_t msg,
    output can_dlc_t  msg_bytes,
    output logic      msg_fresh
);

    rx_state_e  state;
    logic [4:0] id_bit;
    logic [5:0] bit_cnt;    // Shared count for DLC, data, CRC and the trailing fields
    logic [5:0] data_idx;
    can_dlc_t   dlc_sr;
    can_dlc_t   dlc_next;
    can_dlc_t   dlc_cap;
    can_crc_t   crc_rx;
    can_crc_t   crc_value;
    logic       crc_update;
    logic       crc_clear;
    logic       crc_in;
    logic       crc_match;
    logic       crc_ok;
    logic       ack_arm;
    logic       abort;
    logic       frame_start;

    // DLC arrives inverted, MSB first
    assign dlc_next  = {dlc_sr[2:0], ~bit_val};
    assign dlc_cap   = (dlc_next > can_dlc_t'(MAX_DATA_BYTES)) ?
                       can_dlc_t'(MAX_DATA_BYTES) : dlc_next;
    assign crc_match = (crc_rx == crc_value);

    assign abort       = stuff_error && !stuff_bypass;
    assign frame_start = bit_strobe && bit_val &&
                         (state == ST_IDLE ||
                          (state == ST_INTERMISSION &&
                           bit_cnt == 6'(INTERMISSION_BITS - 1)));

    // SOF through the end of data is covered by the CRC
    assign crc_in     = state inside {ST_ID, ST_RTR_SRR, ST_IDE, ST_R1, ST_R0, ST_DLC, ST_DATA};
    assign crc_update = bit_strobe && !abort && (frame_start || crc_in);
    assign crc_clear  = !crc_update && !(crc_in || state == ST_CRC || state == ST_CRC_DELIM);

    can_crc15 u_crc (
        .clk        (clk),
        .rst        (rst),
        .bit_val    (bit_val),
        .crc_update (crc_update),
        .crc_clear  (crc_clear),
        .crc_value  (crc_value)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= ST_IDLE;
            bus_idle     <= 1'b1;
            stuff_bypass <= 1'b1;
            msg_fresh    <= 1'b0;
            ack_arm      <= 1'b0;
            crc_ok       <= 1'b0;
            id_bit       <= '0;
            bit_cnt      <= '0;
            data_idx     <= '0;
        end else if (abort) begin
            state        <= ST_ERROR_FLAG;
            stuff_bypass <= 1'b1;
            ack_arm      <= 1'b0;
        end else if (frame_start) begin
            state        <= ST_ID;
            bus_idle     <= 1'b0;
            stuff_bypass <= 1'b0;
            msg_fresh    <= 1'b0;
            id_bit       <= 5'd28;
        end else if (bit_strobe) begin
            case (state)
                ST_ID: begin
                    id_bit <= id_bit - 5'd1;
                    if (id_bit == 5'd18 || id_bit == 5'd0)
                        state <= ST_RTR_SRR;
                end
                ST_RTR_SRR: state <= extended ? ST_R1 : ST_IDE;
                ST_IDE:     state <= bit_val ? ST_R0 : ST_ID;   // Line 0 means extended
                ST_R1:      state <= ST_R0;
                ST_R0: begin
                    state   <= ST_DLC;
                    bit_cnt <= 6'd3;
                end
                ST_DLC: begin
                    bit_cnt <= bit_cnt - 6'd1;
                    if (bit_cnt == 6'd0) begin
                        if (!rtr && dlc_cap != '0) begin
                            state    <= ST_DATA;
                            bit_cnt  <= {3'(dlc_cap - 4'd1), 3'b111};
                            data_idx <= 6'd63;
                        end else begin
                            state   <= ST_CRC;    // Remote frames carry no data
                            bit_cnt <= 6'd14;
                        end
                    end
                end
                ST_DATA: begin
                    data_idx <= data_idx - 6'd1;
                    bit_cnt  <= bit_cnt - 6'd1;
                    if (bit_cnt == 6'd0) begin
                        state   <= ST_CRC;
                        bit_cnt <= 6'd14;
                    end
                end
                ST_CRC: begin
                    bit_cnt <= bit_cnt - 6'd1;
                    if (bit_cnt == 6'd0)
                        state <= ST_CRC_DELIM;
                end
                ST_CRC_DELIM: begin
                    // Bypass only after the delimiter so a trailing stuff bit is removed
                    stuff_bypass <= 1'b1;
                    if (bit_val) begin
                        state <= ST_ERROR_FLAG;
                    end else begin
                        state   <= ST_ACK_SLOT;
                        ack_arm <= crc_match;
                        crc_ok  <= crc_match;
                    end
                end
                ST_ACK_SLOT: begin
                    state   <= ST_ACK_DELIM;
                    ack_arm <= 1'b0;
                end
                ST_ACK_DELIM: begin
                    if (bit_val || !crc_ok) begin
                        state <= ST_ERROR_FLAG;
                    end else begin
                        state   <= ST_EOF;
                        bit_cnt <= '0;
                    end
                end
                ST_EOF: begin
                    if (bit_val) begin
                        state <= ST_ERROR_FLAG;   // Form error, or overload on the last bit
                    end else begin
                        if (bit_cnt == 6'(EOF_BITS - 2))
                            msg_fresh <= 1'b1;
                        if (bit_cnt == 6'(EOF_BITS - 1)) begin
                            state   <= ST_INTERMISSION;
                            bit_cnt <= '0;
                        end else begin
                            bit_cnt <= bit_cnt + 6'd1;
                        end
                    end
                end
                ST_INTERMISSION: begin
                    if (bit_val) begin
                        state <= ST_ERROR_FLAG;   // Overload frame
                    end else if (bit_cnt == 6'(INTERMISSION_BITS - 1)) begin
                        state    <= ST_IDLE;
                        bus_idle <= 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt + 6'd1;
                    end
                end
                ST_ERROR_FLAG: begin
                    if (!bit_val) begin
                        state   <= ST_ERROR_DELIM;
                        bit_cnt <= 6'd1;      // This recessive bit opens the delimiter
                    end
                end
                ST_ERROR_DELIM: begin
                    if (bit_val) begin
                        state <= ST_ERROR_FLAG;
                    end else if (bit_cnt == 6'(ERR_DELIM_BITS - 1)) begin
                        state   <= ST_INTERMISSION;
                        bit_cnt <= '0;
                    end else begin
                        bit_cnt <= bit_cnt + 6'd1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Captured fields
    always_ff @(posedge clk) begin
        if (frame_start) begin
            msg_id   <= '0;
            extended <= 1'b0;
        end else if (bit_strobe && !abort) begin
            case (state)
                ST_ID:      msg_id[id_bit] <= bit_val;
                ST_RTR_SRR: rtr <= ~bit_val;        // SRR value is overwritten by RTR later
                ST_IDE:     extended <= ~bit_val;
                ST_DLC: begin
                    dlc_sr <= dlc_next;
                    if (bit_cnt == 6'd0)
                        msg_bytes <= dlc_cap;
                end
                ST_DATA:    msg[data_idx] <= bit_val;
                ST_CRC:     crc_rx <= {crc_rx[13:0], bit_val};
                default:    ;
            endcase
        end
    end

    // ACK drive lines up with bit boundaries
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            tx_raw <= 1'b0;
        else if (sync_tick)
            tx_raw <= ack_arm;
    end

endmodule

// ==== src/can_rx_top.sv ====
`timescale 1ns/1ns

module can_rx_top
    import can_rx_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      rx_raw,
    output logic      tx_raw,
    output can_id_t   msg_id,
    output logic      rtr,
    output logic      extended,
    output can_data_t msg,
    output can_dlc_t  msg_bytes,
    output logic      msg_fresh
);

    logic rx_bit;
    logic sample_strobe;
    logic sync_tick;
    logic bit_strobe;
    logic bit_val;
    logic stuff_error;
    logic bus_idle;
    logic stuff_bypass;

    can_bit_sampler u_sampler (
        .clk           (clk),
        .rst           (rst),
        .rx_raw        (rx_raw),
        .bus_idle      (bus_idle),
        .rx_bit        (rx_bit),
        .sample_strobe (sample_strobe),
        .sync_tick     (sync_tick)
    );

    can_destuffer u_destuffer (
        .clk           (clk),
        .rst           (rst),
        .sample_strobe (sample_strobe),
        .rx_bit        (rx_bit),
        .stuff_bypass  (stuff_bypass),
        .bit_strobe    (bit_strobe),
        .bit_val       (bit_val),
        .stuff_error   (stuff_error)
    );

    can_frame_decoder u_decoder (
        .clk          (clk),
        .rst          (rst),
        .bit_strobe   (bit_strobe),
        .bit_val      (bit_val),
        .stuff_error  (stuff_error),
        .sync_tick    (sync_tick),
        .bus_idle     (bus_idle),
        .stuff_bypass (stuff_bypass),
        .tx_raw       (tx_raw),
        .msg_id       (msg_id),
        .rtr          (rtr),
        .extended     (extended),
        .msg          (msg),
        .msg_bytes    (msg_bytes),
        .msg_fresh    (msg_fresh)
    );

endmodule

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;    // 4 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

// ==== tb/can_rx_sva.sv ====
`timescale 1ns/1ns

module can_rx_sva
    import can_rx_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      sync_tick,
    input logic      tx_raw,
    input can_data_t msg,
    input logic      msg_fresh
);

    // No stale message right out of reset
    fresh_after_reset: assert property (@(posedge clk) $fell(rst) |-> !msg_fresh)
        else $error("msg_fresh set in the cycle after reset");

    // ACK drive only moves on bit boundaries
    tx_on_boundary: assert property (@(posedge clk) disable iff (rst)
        (tx_raw != $past(tx_raw)) |-> $past(sync_tick))
        else $error("tx_raw changed outside the cycle after sync_tick");

    msg_held: assert property (@(posedge clk) disable iff (rst)
        (msg_fresh && $past(msg_fresh)) |-> (msg === $past(msg)))
        else $error("msg changed while msg_fresh was high");

endmodule

// ==== tb/can_rx_tb.sv ====
`timescale 1ns/1ns

module can_rx_tb
    import can_rx_pkg::*;
();

    localparam int NUM_TESTS = 8;
    localparam int IDLE_BITS = 20;

    logic      clk;
    logic      rst;
    logic      rx_raw;
    logic      tx_raw;
    can_id_t   msg_id;
    logic      rtr;
    logic      extended;
    can_data_t msg;
    can_dlc_t  msg_bytes;
    logic      msg_fresh;

    // Stimulus and expected results, one row per frame
    string     t_name    [NUM_TESTS];
    can_id_t   t_id      [NUM_TESTS];
    logic      t_ext     [NUM_TESTS];
    logic      t_rtr     [NUM_TESTS];
    can_dlc_t  t_dlc     [NUM_TESTS];
    can_data_t t_data    [NUM_TESTS];
    logic      t_bad_crc [NUM_TESTS];
    logic      t_bad_stuff [NUM_TESTS];
    logic      t_expect  [NUM_TESTS];

    logic frame_q[$];          // Line bits of the current frame
    int   ack_pos;
    int   seed;
    int   fail_count;
    int   cycles;
    int   cycle_limit;

    tb_clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    can_rx_top dut (
        .clk       (clk),
        .rst       (rst),
        .rx_raw    (rx_raw),
        .tx_raw    (tx_raw),
        .msg_id    (msg_id),
        .rtr       (rtr),
        .extended  (extended),
        .msg       (msg),
        .msg_bytes (msg_bytes),
        .msg_fresh (msg_fresh)
    );

    bind can_rx_top can_rx_sva u_sva (
        .clk       (clk),
        .rst       (rst),
        .sync_tick (sync_tick),
        .tx_raw    (tx_raw),
        .msg       (msg),
        .msg_fresh (msg_fresh)
    );

    task automatic id_check(input string name, input can_id_t exp, input can_id_t act);
        if (exp !== act) begin
            fail_count++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "Identifier mismatch");
        end
    endtask

    task automatic data_check(input string name, input can_data_t exp, input can_data_t act);
        if (exp !== act) begin
            fail_count++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "Data mismatch");
        end
    endtask

    task automatic dlc_check(input string name, input can_dlc_t exp, input can_dlc_t act);
        if (exp !== act) begin
            fail_count++;
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "Length mismatch");
        end
    endtask

    task automatic flag_check(input string name, input bit exp, input bit act);
        if (exp !== act) begin
            fail_count++;
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "Flag mismatch");
        end
    endtask

    function automatic int data_bytes(input int n);
        int cap;
        cap = (t_dlc[n] > 4'd8) ? MAX_DATA_BYTES : int'(t_dlc[n]);
        return t_rtr[n] ? 0 : cap;
    endfunction

    task automatic add_row(input int n, input string name, input can_id_t id, input logic ext,
                           input logic is_rtr, input can_dlc_t dlc, input logic bad_crc,
                           input logic bad_stuff, input logic expect_msg);
        t_name[n]      = name;
        t_id[n]        = id;
        t_ext[n]       = ext;
        t_rtr[n]       = is_rtr;
        t_dlc[n]       = dlc;
        t_data[n]      = {$random(seed), $random(seed)};
        t_bad_crc[n]   = bad_crc;
        t_bad_stuff[n] = bad_stuff;
        t_expect[n]    = expect_msg;
    endtask

    // Serialise one table row into frame_q, stuffed, with trailer
    task automatic build_frame(input int n);
        logic     raw[$];
        can_crc_t crc;
        logic     fb;
        logic     last;
        int       run;
        int       i;
        int       limit;
        raw.delete();
        frame_q.delete();
        raw.push_back(1'b1);                      // SOF
        for (i = 28; i >= 18; i--)
            raw.push_back(t_id[n][i]);
        if (t_ext[n]) begin
            raw.push_back(1'b0);                  // SRR
            raw.push_back(1'b0);                  // IDE, extended
            for (i = 17; i >= 0; i--)
                raw.push_back(t_id[n][i]);
            raw.push_back(~t_rtr[n]);
            raw.push_back(1'b1);                  // r1
        end else begin
            raw.push_back(~t_rtr[n]);
            raw.push_back(1'b1);                  // IDE, standard
        end
        raw.push_back(1'b1);                      // r0
        for (i = 3; i >= 0; i--)
            raw.push_back(~t_dlc[n][i]);
        for (i = 0; i < data_bytes(n) * 8; i++)
            raw.push_back(t_data[n][63 - i]);
        crc = '0;
        for (i = 0; i < raw.size(); i++) begin
            fb  = raw[i] ^ crc[14];
            crc = {crc[13:0], 1'b0} ^ (fb ? CRC15_POLY : 15'h0);
        end
        if (t_bad_crc[n])
            crc[0] = ~crc[0];
        for (i = 14; i >= 0; i--)
            raw.push_back(crc[i]);

        limit = t_bad_stuff[n] ? 12 : raw.size();  // Violation right after the base ID
        run   = 0;
        last  = 1'b0;
        for (i = 0; i < limit; i++) begin
            frame_q.push_back(raw[i]);
            run  = (i > 0 && raw[i] == last) ? run + 1 : 1;
            last = raw[i];
            if (run == STUFF_RUN) begin
                frame_q.push_back(~last);
                last = ~last;
                run  = 1;
            end
        end
        if (t_bad_stuff[n]) begin
            repeat (STUFF_RUN + 1) frame_q.push_back(~last);
            ack_pos = -1;
        end else begin
            frame_q.push_back(1'b0);              // CRC delimiter
            ack_pos = frame_q.size();
            repeat (2 + EOF_BITS + INTERMISSION_BITS) frame_q.push_back(1'b0);
        end
    endtask

    // One bit time on the line, tx_raw picked up mid-bit
    task automatic drive_bit(input logic b, output logic tx_mid);
        int q;
        rx_raw = b;
        tx_mid = 1'b0;
        for (q = 0; q < int'(BIT_QUANTA); q++) begin
            @(posedge clk);
            #1;
            if (q == int'(BIT_QUANTA) / 2)
                tx_mid = tx_raw;
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout: run exceeded %0d clock cycles", cycle_limit);
            $display("TEST FAILED");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        int       n;
        int       i;
        int       total_bits;
        int       nbytes;
        logic     tx_mid;
        logic     ack_seen;
        can_id_t  exp_id;
        can_data_t mask;
        rx_raw      = 1'b0;
        fail_count  = 0;
        cycles      = 0;
        cycle_limit = 0;
        seed        = 81;

        add_row(0, "std_data",    can_id_t'(29'h123 << 18), 1'b0, 1'b0, 4'd4,  1'b0, 1'b0, 1'b1);
        add_row(1, "ext_data",    29'h1ABCDE12,             1'b1, 1'b0, 4'd8,  1'b0, 1'b0, 1'b1);
        add_row(2, "std_remote",  can_id_t'(29'h2F0 << 18), 1'b0, 1'b1, 4'd0,  1'b0, 1'b0, 1'b1);
        add_row(3, "dlc_cap",     can_id_t'(29'h055 << 18), 1'b0, 1'b0, 4'd12, 1'b0, 1'b0, 1'b1);
        add_row(4, "bad_crc",     can_id_t'(29'h3A5 << 18), 1'b0, 1'b0, 4'd2,  1'b1, 1'b0, 1'b0);
        add_row(5, "bad_stuff",   can_id_t'(29'h7FF << 18), 1'b0, 1'b0, 4'd3,  1'b0, 1'b1, 1'b0);
        add_row(6, "ext_after",   29'h0F00F00F,             1'b1, 1'b0, 4'd3,  1'b0, 1'b0, 1'b1);
        add_row(7, "std_zeros",   '0,                       1'b0, 1'b0, 4'd1,  1'b0, 1'b0, 1'b1);
        t_data[7] = '0;                            // Long runs force many stuff bits

        total_bits = 4;
        for (n = 0; n < NUM_TESTS; n++) begin
            build_frame(n);
            total_bits += frame_q.size() + IDLE_BITS;
        end
        cycle_limit = 2 * total_bits * int'(BIT_QUANTA);

        while (rst !== 1'b0)
            @(posedge clk);
        #1;
        repeat (4) drive_bit(1'b0, tx_mid);

        for (n = 0; n < NUM_TESTS; n++) begin
            build_frame(n);
            ack_seen = 1'b0;
            for (i = 0; i < frame_q.size(); i++) begin
                drive_bit(frame_q[i], tx_mid);
                if (i == ack_pos)
                    ack_seen = tx_mid;
            end
            if (ack_pos >= 0)
                flag_check({t_name[n], " ack"}, t_expect[n], ack_seen);
            flag_check({t_name[n], " msg_fresh"}, t_expect[n], msg_fresh);
            if (t_expect[n]) begin
                exp_id = t_ext[n] ? t_id[n] : {t_id[n][28:18], 18'h0};
                id_check({t_name[n], " msg_id"}, exp_id, msg_id);
                flag_check({t_name[n], " rtr"}, t_rtr[n], rtr);
                flag_check({t_name[n], " extended"}, t_ext[n], extended);
                dlc_check({t_name[n], " msg_bytes"},
                          (t_dlc[n] > 4'd8) ? 4'd8 : t_dlc[n], msg_bytes);
                nbytes = data_bytes(n);
                if (nbytes > 0) begin
                    mask = '1;
                    mask = mask << (64 - nbytes * 8);   // Only the received bytes
                    data_check({t_name[n], " msg"}, t_data[n] & mask, msg & mask);
                end
            end
            repeat (IDLE_BITS) drive_bit(1'b0, tx_mid);
        end

        if (fail_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== sources.f ====
common/can_rx_pkg.sv
bit_timing/can_bit_sampler.sv
src/can_destuffer.sv
src/can_crc15.sv
frame_rx/can_frame_decoder.sv
src/can_rx_top.sv
tb/tb_clk_gen.sv
tb/can_rx_sva.sv
tb/can_rx_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := can_rx_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := run.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
